//--- Bender.yml
package:
  name: imuldiv

export_include_dirs:
  - hw

sources:
  # packages first, the RTL units depend on them
  - hw/imuldiv_msg_pkg.sv
  - hw/imuldiv_ctrl_pkg.sv
  - hw/imuldiv_int_div_dpath.sv
  - hw/imuldiv_int_div_ctrl.sv
  - hw/imuldiv_int_div_iterative.sv
  - hw/imuldiv_int_mul_iterative.sv
  - hw/imuldiv_unit.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/imuldiv_tb.sv

//--- tb.f
+incdir+hw
hw/imuldiv_msg_pkg.sv
hw/imuldiv_ctrl_pkg.sv
hw/imuldiv_int_div_dpath.sv
hw/imuldiv_int_div_ctrl.sv
hw/imuldiv_int_div_iterative.sv
hw/imuldiv_int_mul_iterative.sv
hw/imuldiv_unit.sv
dv/imuldiv_tb.sv

//--- dv/imuldiv_tb.sv
`timescale 1ns/1ns
// directed testbench for the multiply/divide unit
// results come from a reference model, also checks latency and back-pressure

`include "imuldiv_params.svh"

module imuldiv_tb
  import imuldiv_msg_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int LATENCY = `IMULDIV_XLEN;  // one edge per iteration, DONE on the last
  localparam int NUM_OPS = 80;              // upper bound on requests issued below
  localparam logic [31:0] MOST_NEG = 32'h8000_0000;
  localparam logic [31:0] MOST_POS = 32'h7fff_ffff;

  logic                     clk;
  logic                     reset;
  imuldiv_fn_e              req_fn;
  logic [`IMULDIV_XLEN-1:0] req_a;
  logic [`IMULDIV_XLEN-1:0] req_b;
  logic                     req_val;
  logic                     req_rdy;
  imuldiv_result_u          resp_result;
  logic                     resp_val;
  logic                     resp_rdy;
  int                       checks;
  int                       errors;

  imuldiv_unit u_dut (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------
  // reference model
  // --------------------
  // signed product, or truncating divide on magnitudes with sign fix-up
  function automatic imuldiv_result_u model(input imuldiv_fn_e fn, input logic [31:0] a,
                                            input logic [31:0] b);
    imuldiv_result_u r;
    longint sa;
    longint sb;
    longint ma;
    longint mb;
    longint qm;
    longint rm;
    r = '0;
    if (fn == MUL) begin
      r.prod = longint'($signed(a)) * longint'($signed(b));
      return r;
    end
    sa = (fn == DIV) ? longint'($signed(a)) : longint'(a);
    sb = (fn == DIV) ? longint'($signed(b)) : longint'(b);
    ma = (sa < 0) ? -sa : sa;
    mb = (sb < 0) ? -sb : sb;
    // zero divisor: all-ones quotient, dividend left as remainder
    if (mb == 0) begin
      qm = 64'hffff_ffff;
      rm = ma;
    end else begin
      qm = ma / mb;
      rm = ma % mb;
    end
    if ((sa < 0) != (sb < 0)) begin
      qm = -qm;
    end
    // remainder follows the dividend
    if (sa < 0) begin
      rm = -rm;
    end
    r.div.quot = qm[31:0];
    r.div.rem  = rm[31:0];
    return r;
  endfunction

  task automatic check_word(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  // --------------------
  // one request/response
  // --------------------
  // holds resp_rdy low for hold cycles once the response shows
  task automatic run_op(input string name, input imuldiv_fn_e fn, input logic [31:0] a,
                        input logic [31:0] b, input int hold, output imuldiv_result_u res);
    logic took;
    int   lat;
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    req_val = 1'b1;
    do begin
      took = req_rdy;
      @(posedge clk);
      #2;
    end while (!took);
    req_val = 1'b0;
    lat = 0;
    while (!resp_val) begin
      @(posedge clk);
      #2;
      lat++;
    end
    check_word({name, "_latency"}, LATENCY, lat);
    res = resp_result;
    for (int i = 0; i < hold; i++) begin
      @(posedge clk);
      #2;
      checks++;
      assert (resp_val && !req_rdy) else begin
        $display("%s: response dropped or request taken under back-pressure", name);
        errors++;
      end
      check_word({name, "_held"}, res, resp_result);
    end
    resp_rdy = 1'b1;
    @(posedge clk);
    #2;
    resp_rdy = 1'b0;
  endtask

  task automatic check_op(input string name, input imuldiv_fn_e fn, input logic [31:0] a,
                          input logic [31:0] b, input int hold);
    imuldiv_result_u exp;
    imuldiv_result_u act;
    exp = model(fn, a, b);
    run_op(name, fn, a, b, hold, act);
    if (fn == MUL) begin
      check_word({name, "_prod"}, exp.prod, act.prod);
    end else begin
      check_word({name, "_quot"}, exp.div.quot, act.div.quot);
      check_word({name, "_rem"}, exp.div.rem, act.div.rem);
    end
  endtask

  // --------------------
  // tests
  // --------------------
  task automatic test_reset_state();
    check_word("reset_resp_val", 64'd0, resp_val);
    check_word("reset_req_rdy", 64'd1, req_rdy);
  endtask

  task automatic test_mul();
    logic [31:0] ca [7] = '{32'd0, 32'd1, 32'hffff_ffff, MOST_NEG, MOST_POS, MOST_NEG, MOST_POS};
    logic [31:0] cb [7] = '{32'd5, 32'hffff_fff9, 32'hffff_ffff, MOST_NEG, MOST_POS, MOST_POS,
                            32'hffff_ffff};
    for (int i = 0; i < 7; i++) begin
      check_op($sformatf("mul_corner%0d", i), MUL, ca[i], cb[i], 0);
    end
    for (int i = 0; i < 20; i++) begin
      check_op($sformatf("mul_rand%0d", i), MUL, $urandom, $urandom, 0);
    end
  endtask

  task automatic test_div();
    // every sign combination, most negative by minus one, small over large
    logic [31:0] ca [6] = '{32'd100, -32'd100, 32'd100, -32'd100, MOST_NEG, 32'd7};
    logic [31:0] cb [6] = '{32'd7, 32'd7, -32'd7, -32'd7, 32'hffff_ffff, 32'd100};
    for (int i = 0; i < 6; i++) begin
      check_op($sformatf("div_corner%0d", i), DIV, ca[i], cb[i], 0);
      check_op($sformatf("divu_corner%0d", i), DIVU, ca[i], cb[i], 0);
    end
    for (int i = 0; i < 10; i++) begin
      check_op($sformatf("div_rand%0d", i), DIV, $urandom, $urandom >> (i % 24), 0);
      check_op($sformatf("divu_rand%0d", i), DIVU, $urandom, $urandom >> (i % 24), 0);
    end
  endtask

  task automatic test_div_by_zero();
    check_op("div_zero_pos", DIV, 32'd1234, 32'd0, 0);
    check_op("div_zero_neg", DIV, -32'd1234, 32'd0, 0);
    check_op("divu_zero_pos", DIVU, 32'd1234, 32'd0, 0);
    check_op("divu_zero_big", DIVU, -32'd1234, 32'd0, 0);
  endtask

  task automatic test_backpressure();
    check_op("bp_mul", MUL, $urandom, $urandom, $urandom_range(3, 15));
    check_op("bp_div", DIV, $urandom, $urandom_range(1, 1000), $urandom_range(3, 15));
  endtask

  // each request goes in right after the previous transfer
  task automatic test_alternation();
    for (int i = 0; i < 8; i++) begin
      checks++;
      assert (req_rdy) else begin
        $display("alternation %0d: unit not ready right after the response transfer", i);
        errors++;
      end
      if (i % 2 == 0) begin
        check_op($sformatf("alt_mul%0d", i), MUL, $urandom, $urandom, 0);
      end else begin
        check_op($sformatf("alt_div%0d", i), DIV, $urandom, $urandom_range(1, 5000), 0);
      end
    end
  endtask

  // --------------------
  // main sequence and watchdog
  // --------------------
  initial begin
    void'($urandom(10));
    checks   = 0;
    errors   = 0;
    req_fn   = MUL;
    req_a    = '0;
    req_b    = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    reset    = 1'b1;
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;
    test_reset_state();
    test_mul();
    test_div();
    test_div_by_zero();
    test_backpressure();
    test_alternation();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // each operation fits well inside 40 cycles, plus room for reset
  initial begin
    #(NUM_OPS * 40 * CLK_PERIOD + 200 * CLK_PERIOD);
    $display("timeout: the unit stopped responding, %0d errors so far", errors);
    $display("Test failed");
    $finish;
  end

endmodule

//--- hw/imuldiv_unit.sv
`timescale 1ns/1ns
// multiply/divide unit top, dispatches one request at a time by function code
// and returns the owning unit's response, no added latency

`include "imuldiv_params.svh"

module imuldiv_unit
  import imuldiv_msg_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  imuldiv_fn_e              req_fn,
  input  logic [`IMULDIV_XLEN-1:0] req_a,
  input  logic [`IMULDIV_XLEN-1:0] req_b,
  input  logic                     req_val,
  output logic                     req_rdy,
  output imuldiv_result_u          resp_result,
  output logic                     resp_val,
  input  logic                     resp_rdy
);

  logic            sel_div;     // decoded target of the incoming request
  logic            busy;        // an operation is in flight
  logic            owner_div;   // in-flight operation belongs to the divider
  logic            mul_req_val;
  logic            mul_req_rdy;
  logic            mul_resp_val;
  logic            mul_resp_rdy;
  imuldiv_result_u mul_result;
  logic            div_req_val;
  logic            div_req_rdy;
  logic            div_resp_val;
  logic            div_resp_rdy;
  imuldiv_result_u div_result;

  // --------------------
  // request dispatch
  // --------------------
  assign sel_div     = (req_fn != MUL);
  assign req_rdy     = ~busy & (sel_div ? div_req_rdy : mul_req_rdy);
  assign mul_req_val = req_val & ~busy & ~sel_div;
  assign div_req_val = req_val & ~busy & sel_div;

  // owner tracking, cleared by the response transfer
  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      owner_div <= 1'b0;
    end else if (req_val && req_rdy) begin
      busy      <= 1'b1;
      owner_div <= sel_div;
    end else if (resp_val && resp_rdy) begin
      busy      <= 1'b0;
    end
  end

  imuldiv_int_mul_iterative u_mul (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (mul_req_val),
    .req_rdy     (mul_req_rdy),
    .resp_result (mul_result),
    .resp_val    (mul_resp_val),
    .resp_rdy    (mul_resp_rdy)
  );

  imuldiv_int_div_iterative u_div (
    .clk         (clk),
    .reset       (reset),
    .req_signed  (req_fn == DIV),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (div_req_val),
    .req_rdy     (div_req_rdy),
    .resp_result (div_result),
    .resp_val    (div_resp_val),
    .resp_rdy    (div_resp_rdy)
  );

  // --------------------
  // response steering
  // --------------------
  // only the owner sees resp_rdy
  assign mul_resp_rdy = resp_rdy & busy & ~owner_div;
  assign div_resp_rdy = resp_rdy & busy & owner_div;
  assign resp_val     = busy & (owner_div ? div_resp_val : mul_resp_val);
  assign resp_result  = owner_div ? div_result : mul_result;

  // one operation in flight, so at most one unit can be done
  a_one_resp: assert property (@(posedge clk) disable iff (reset)
    !(mul_resp_val && div_resp_val));

endmodule

//--- hw/imuldiv_int_mul_iterative.sv
`timescale 1ns/1ns
// iterative signed shift-add multiplier, one multiplier bit per cycle
// same IDLE/CALC/DONE timing and val/rdy as the divider

`include "imuldiv_params.svh"

module imuldiv_int_mul_iterative
  import imuldiv_msg_pkg::*;
  import imuldiv_ctrl_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic [`IMULDIV_XLEN-1:0] req_a,
  input  logic [`IMULDIV_XLEN-1:0] req_b,
  input  logic                     req_val,
  output logic                     req_rdy,
  output imuldiv_result_u          resp_result,
  output logic                     resp_val,
  input  logic                     resp_rdy
);

  localparam int XLEN = `IMULDIV_XLEN;
  localparam logic [`IMULDIV_CNT_W-1:0] LAST_ITER = `IMULDIV_CNT_W'(XLEN - 1);

  imuldiv_iter_state_e       state;
  logic [`IMULDIV_CNT_W-1:0] count;
  logic                      accept;
  logic                      xfer;

  logic [2*XLEN-1:0]         mcand;   // multiplicand, moves left each step
  logic [XLEN-1:0]           mplier;  // multiplier, moves right each step
  logic [2*XLEN-1:0]         acc;
  logic                      neg;     // product sign
  logic [XLEN-1:0]           mag_a;
  logic [XLEN-1:0]           mag_b;

  assign accept = req_val & req_rdy;
  assign xfer   = resp_val & resp_rdy;
  assign mag_a  = req_a[XLEN-1] ? -req_a : req_a;
  assign mag_b  = req_b[XLEN-1] ? -req_b : req_b;

  // --------------------
  // FSM
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: if (accept) begin
          state <= CALC;
          count <= '0;
        end
        CALC: if (count == LAST_ITER) state <= DONE;
          else count <= count + 1'b1;
        DONE: if (xfer) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // --------------------
  // shift-add datapath
  // --------------------
  always_ff @(posedge clk) begin
    if (accept) begin
      mcand  <= {{XLEN{1'b0}}, mag_a};
      mplier <= mag_b;
      acc    <= '0;
      neg    <= req_a[XLEN-1] ^ req_b[XLEN-1];
    end else if (state == CALC) begin
      // add when the current multiplier bit is set
      if (mplier[0]) acc <= acc + mcand;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  assign req_rdy = (state == IDLE);
  assign resp_val = (state == DONE);
  // magnitude product fits 64 bits even for most negative squared
  assign resp_result.prod = neg ? -acc : acc;

  // result must hold while waiting on back-pressure
  a_acc_hold: assert property (@(posedge clk) disable iff (reset)
    (state == DONE) |=> $stable(acc));

endmodule

//--- hw/imuldiv_int_div_iterative.sv
`timescale 1ns/1ns
// iterative restoring divider, control and datapath joined
// handles signed and unsigned divides with val/rdy on both sides

`include "imuldiv_params.svh"

module imuldiv_int_div_iterative
  import imuldiv_msg_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req_signed,
  input  logic [`IMULDIV_XLEN-1:0] req_a,
  input  logic [`IMULDIV_XLEN-1:0] req_b,
  input  logic                     req_val,
  output logic                     req_rdy,
  output imuldiv_result_u          resp_result,
  output logic                     resp_val,
  input  logic                     resp_rdy
);

  // control to datapath
  logic a_en;
  logic b_en;
  logic a_mux_sel;
  logic sub_mux_sel;

  imuldiv_int_div_dpath u_dpath (
    .clk         (clk),
    .reset       (reset),
    .req_signed  (req_signed),
    .req_a       (req_a),
    .req_b       (req_b),
    .a_en        (a_en),
    .b_en        (b_en),
    .a_mux_sel   (a_mux_sel),
    .sub_mux_sel (sub_mux_sel),
    .resp_result (resp_result)
  );

  imuldiv_int_div_ctrl u_ctrl (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .resp_rdy    (resp_rdy),
    .req_rdy     (req_rdy),
    .resp_val    (resp_val),
    .a_en        (a_en),
    .b_en        (b_en),
    .a_mux_sel   (a_mux_sel),
    .sub_mux_sel (sub_mux_sel)
  );

endmodule

//--- hw/imuldiv_int_div_ctrl.sv
`timescale 1ns/1ns
// divider control, IDLE/CALC/DONE FSM with its own iteration count
// drives the datapath enables and selects plus the val/rdy pair

`include "imuldiv_params.svh"

module imuldiv_int_div_ctrl
  import imuldiv_ctrl_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  input  logic resp_rdy,
  output logic req_rdy,
  output logic resp_val,
  output logic a_en,
  output logic b_en,
  output logic a_mux_sel,
  output logic sub_mux_sel
);

  localparam logic [`IMULDIV_CNT_W-1:0] LAST_ITER = `IMULDIV_CNT_W'(`IMULDIV_XLEN - 1);

  imuldiv_iter_state_e         state;
  logic [`IMULDIV_CNT_W-1:0]   count;
  logic                        accept;
  logic                        xfer;

  assign accept = req_val & req_rdy;
  assign xfer   = resp_val & resp_rdy;

  // --------------------
  // state and count
  // --------------------
  // 32 cycles in CALC, DONE shows on the 32nd edge after the accepting one
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: if (accept) begin
          state <= CALC;
          count <= '0;
        end
        CALC: if (count == LAST_ITER) state <= DONE;
          else count <= count + 1'b1;
        DONE: if (xfer) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // --------------------
  // outputs from state
  // --------------------
  assign req_rdy     = (state == IDLE);
  assign resp_val    = (state == DONE);
  // load on acceptance, then one step per CALC cycle
  assign a_en        = (state == CALC) | accept;
  assign b_en        = accept;
  assign a_mux_sel   = (state == CALC);
  assign sub_mux_sel = (state == CALC);

  // a request is never offered while a result is pending
  a_rdy_val_excl: assert property (@(posedge clk) disable iff (reset)
    !(req_rdy && resp_val));

endmodule

//--- hw/imuldiv_int_div_dpath.sv
`timescale 1ns/1ns
// restoring divider datapath, one quotient bit per cycle
// sequenced by imuldiv_int_div_ctrl through enables and mux selects

`include "imuldiv_params.svh"

module imuldiv_int_div_dpath
  import imuldiv_msg_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req_signed,
  input  logic [`IMULDIV_XLEN-1:0] req_a,
  input  logic [`IMULDIV_XLEN-1:0] req_b,
  input  logic                     a_en,
  input  logic                     b_en,
  input  logic                     a_mux_sel,
  input  logic                     sub_mux_sel,
  output imuldiv_result_u          resp_result
);

  localparam int XLEN = `IMULDIV_XLEN;
  localparam int RW = 2 * XLEN + 1;

  // remainder sits in [2*XLEN:XLEN], quotient bits shift in at bit 0
  logic [RW-1:0]   a_reg;
  // divisor lined up with the remainder half
  logic [RW-1:0]   b_reg;
  // sign flags, already qualified by signed mode
  logic            neg_a;
  logic            neg_b;

  logic            in_neg_a;
  logic            in_neg_b;
  logic [XLEN-1:0] mag_a;
  logic [XLEN-1:0] mag_b;
  logic [RW-1:0]   initial_a;
  logic [RW-1:0]   initial_b;
  logic [RW-1:0]   a_shift;
  logic [RW-1:0]   sub_out;
  logic [RW-1:0]   trial;
  logic [RW-1:0]   sub_mux_out;
  logic [RW-1:0]   a_mux_out;
  logic [XLEN-1:0] quot_mag;
  logic [XLEN-1:0] rem_mag;

  // --------------------
  // operand load
  // --------------------
  // unsigned divides never take the negate path
  assign in_neg_a  = req_signed & req_a[XLEN-1];
  assign in_neg_b  = req_signed & req_b[XLEN-1];
  assign mag_a     = in_neg_a ? -req_a : req_a;
  assign mag_b     = in_neg_b ? -req_b : req_b;
  assign initial_a = {{(XLEN + 1){1'b0}}, mag_a};
  assign initial_b = {1'b0, mag_b, {XLEN{1'b0}}};

  // --------------------
  // shift, subtract, restore
  // --------------------
  assign a_shift = a_reg << 1;
  assign sub_out = a_shift - b_reg;
  // negative difference means the divisor did not fit, restore and shift in 0
  assign trial = sub_out[RW-1] ? {a_shift[RW-1:1], 1'b0} : {sub_out[RW-1:1], 1'b1};
  assign sub_mux_out = sub_mux_sel ? trial : a_shift;
  assign a_mux_out = a_mux_sel ? sub_mux_out : initial_a;

  always_ff @(posedge clk) begin
    if (reset) begin
      a_reg <= '0;
      b_reg <= '0;
      neg_a <= 1'b0;
      neg_b <= 1'b0;
    end else begin
      if (a_en) begin
        a_reg <= a_mux_out;
      end
      // divisor and signs only change when a request is taken
      if (b_en) begin
        b_reg <= initial_b;
        neg_a <= in_neg_a;
        neg_b <= in_neg_b;
      end
    end
  end

  // --------------------
  // sign correction
  // --------------------
  assign quot_mag = a_reg[XLEN-1:0];
  assign rem_mag  = a_reg[2*XLEN-1:XLEN];

  // quotient negative when the signs differ, remainder follows the dividend
  always_comb begin
    resp_result.div.quot = (neg_a ^ neg_b) ? -quot_mag : quot_mag;
    resp_result.div.rem  = neg_a ? -rem_mag : rem_mag;
  end

endmodule

//--- hw/imuldiv_ctrl_pkg.sv
// control types shared by the iterative divider and multiplier
// import where an iteration FSM is built

package imuldiv_ctrl_pkg;

  // --------------------
  // iteration FSM state
  // --------------------
  // IDLE waits for a request, CALC runs one step per cycle,
  // DONE holds the result until the response is taken
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } imuldiv_iter_state_e;

endpackage

//--- hw/imuldiv_msg_pkg.sv
// request and response message types of the multiply/divide unit
// imported by the units, the top level and the testbench

`include "imuldiv_params.svh"

package imuldiv_msg_pkg;

  // --------------------
  // request function code
  // --------------------
  typedef enum logic [1:0] {
    MUL  = 2'd0,  // signed product
    DIV  = 2'd1,  // signed quotient and remainder
    DIVU = 2'd2   // unsigned quotient and remainder
  } imuldiv_fn_e;

  // --------------------
  // response word
  // --------------------
  // same 64 bits, read as a product for MUL
  // or as remainder (upper half) and quotient (lower half) for divides
  typedef union packed {
    logic [2*`IMULDIV_XLEN-1:0] prod;
    struct packed {
      logic [`IMULDIV_XLEN-1:0] rem;
      logic [`IMULDIV_XLEN-1:0] quot;
    } div;
  } imuldiv_result_u;

endpackage

//--- hw/imuldiv_params.svh
// width macros shared by the multiply/divide RTL and its testbench
// include wherever operand or counter widths are needed

`ifndef IMULDIV_PARAMS_SVH
`define IMULDIV_PARAMS_SVH

// operand width, results are twice this
`define IMULDIV_XLEN 32

// iteration counter width, must hold IMULDIV_XLEN - 1
`define IMULDIV_CNT_W 6

`endif
